/* hdl/prf_free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module prf_free_list
   import rob_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  pop,
   input  logic  push_valid,
   input  t_preg push_pdst,
   output t_preg head_pdst,
   output logic  avail
);

   localparam int FL_DEPTH = `NUM_PREGS - `NUM_AREGS;
   localparam int PTR_W    = $clog2(FL_DEPTH);
   localparam int CNT_W    = $clog2(FL_DEPTH + 1);

   t_preg              fifo [FL_DEPTH];
   logic [PTR_W-1:0]   rd_ptr;
   logic [PTR_W-1:0]   wr_ptr;
   logic [CNT_W-1:0]   count;
   logic               do_pop;

   assign avail     = (count != '0);
   assign head_pdst = fifo[rd_ptr];
   assign do_pop    = pop && avail;

   always_ff @(posedge clk) begin
      if (reset) begin
         // Every id above the architectural range starts out free
         for (int i = 0; i < FL_DEPTH; i++) begin
            fifo[i] <= t_preg'(`NUM_AREGS + i);
         end
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= CNT_W'(FL_DEPTH);
      end else begin
         if (push_valid) begin
            fifo[wr_ptr] <= push_pdst;
            wr_ptr <= (wr_ptr == PTR_W'(FL_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(FL_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (push_valid && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !push_valid) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/rename_map.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rename_map
   import rob_pkg::*;
(
   input  logic  clk,
   input  logic  reset,
   input  logic  alloc,
   input  logic  alloc_has_dst,
   input  t_areg alloc_dst_reg,
   input  t_preg alloc_pdst_new,
   input  t_areg src_reg_0,
   input  t_areg src_reg_1,
   input  logic  restore_valid,
   input  t_areg restore_areg,
   input  t_preg restore_pdst_old,
   output t_preg alloc_pdst_old,
   output t_preg src_pdst_0,
   output t_preg src_pdst_1
);

   t_preg map [`NUM_AREGS];

   // Reads see the mapping from before this cycle's rename
   assign alloc_pdst_old = map[alloc_dst_reg];
   assign src_pdst_0     = map[src_reg_0];
   assign src_pdst_1     = map[src_reg_1];

   // Out of reset every architectural register maps onto itself
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < `NUM_AREGS; i++) begin
            map[i] <= t_preg'(i);
         end
      end else if (restore_valid) begin
         map[restore_areg] <= restore_pdst_old;
      end else if (alloc && alloc_has_dst) begin
         map[alloc_dst_reg] <= alloc_pdst_new;
      end
   end

endmodule

`default_nettype wire

/* hdl/rob.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob
   import rob_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    alloc,
   input  logic    alloc_has_dst,
   input  t_areg   alloc_dst_reg,
   input  t_preg   alloc_pdst_new,
   input  t_preg   alloc_pdst_old,
   input  logic    free_avail,
   input  logic    result_valid,
   input  t_rob_id result_robid,
   input  logic    result_flush,
   input  t_areg   src_reg_0,
   input  t_areg   src_reg_1,
   output logic    ready,
   output t_rob_id alloc_robid,
   output logic    src_pending_0,
   output logic    src_pending_1,
   output t_rob_id src_robid_0,
   output t_rob_id src_robid_1,
   output logic    retire_valid,
   output t_rob_id retire_robid,
   output t_areg   retire_dst_reg,
   output logic    free_push_valid,
   output t_preg   free_push_pdst,
   output logic    restore_valid,
   output t_areg   restore_areg,
   output t_preg   restore_pdst_old,
   output logic    nuke,
   output logic    resume_fetch
);

   localparam int QCNT_W = $clog2(`QUIESCE_CYCLES + 1);

   t_rob_id   head;
   t_rob_id   tail;
   t_rob_ent  entries [`ROB_NUM_ENTS];
   t_rob_ent  head_ent;
   t_rob_ent  walk_ent;
   logic      full;
   logic      do_alloc;
   logic      walk_on;
   logic [`ROB_NUM_ENTS-1:0] e_alloc;
   logic [`ROB_NUM_ENTS-1:0] e_result;
   logic [`ROB_NUM_ENTS-1:0] e_retire;
   logic [`ROB_NUM_ENTS-1:0] src_match_0;
   logic [`ROB_NUM_ENTS-1:0] src_match_1;
   t_rob_idx  src_idx_0;
   t_rob_idx  src_idx_1;
   t_rr_state rr_state;
   t_rob_id   rr_ptr;
   logic [QCNT_W-1:0] rr_cnt;

   // Search backward from the youngest slot, returns {found, index}
   function automatic logic [`ROB_ID_W:0] youngest_match(
      input logic [`ROB_NUM_ENTS-1:0] match,
      input t_rob_idx                 top
   );
      t_rob_idx idx;
      t_rob_idx pick;
      logic     found;
      found = 1'b0;
      pick  = '0;
      for (int i = 0; i < `ROB_NUM_ENTS; i++) begin
         idx = top - t_rob_idx'(i);
         if (!found && match[idx]) begin
            found = 1'b1;
            pick  = idx;
         end
      end
      return {found, pick};
   endfunction

   assign head_ent = entries[head.idx];
   assign walk_ent = entries[rr_ptr.idx];
   assign full     = (head.idx == tail.idx) && (head.wrap != tail.wrap);

   // Retire
   assign retire_valid   = head_ent.valid && head_ent.ready && (rr_state == RR_IDLE);
   assign retire_robid   = head;
   assign retire_dst_reg = head_ent.dst_areg;
   assign nuke           = retire_valid && head_ent.flush_needed;

   // A micro-op accepted next to a nuke would already be younger than the flush
   assign ready       = !full && free_avail && (rr_state == RR_IDLE) && !nuke;
   assign do_alloc    = alloc && ready;
   assign alloc_robid = tail;

   always_comb begin
      for (int i = 0; i < `ROB_NUM_ENTS; i++) begin
         e_alloc[i]  = do_alloc && (tail.idx == t_rob_idx'(i));
         e_result[i] = result_valid && (result_robid.idx == t_rob_idx'(i));
         e_retire[i] = retire_valid && (head.idx == t_rob_idx'(i));
      end
   end

   for (genvar i = 0; i < `ROB_NUM_ENTS; i++) begin : g_ent
      rob_entry u_ent (
         .clk,
         .reset,
         .alloc_en       (e_alloc[i]),
         .alloc_has_dst,
         .alloc_dst_areg (alloc_dst_reg),
         .alloc_pdst_new,
         .alloc_pdst_old,
         .result_en      (e_result[i]),
         .result_flush,
         .retire_en      (e_retire[i]),
         .flush_young    (nuke),
         .entry          (entries[i])
      );
   end

   // Source lookup over the entries valid before this allocation
   always_comb begin
      for (int i = 0; i < `ROB_NUM_ENTS; i++) begin
         src_match_0[i] = entries[i].valid && entries[i].has_dst &&
                          (entries[i].dst_areg == src_reg_0);
         src_match_1[i] = entries[i].valid && entries[i].has_dst &&
                          (entries[i].dst_areg == src_reg_1);
      end
      {src_pending_0, src_idx_0} = youngest_match(src_match_0, decr_robid(tail).idx);
      {src_pending_1, src_idx_1} = youngest_match(src_match_1, decr_robid(tail).idx);
      // Slots at or above the head index belong to the head's lap
      src_robid_0.idx  = src_idx_0;
      src_robid_0.wrap = (src_idx_0 >= head.idx) ? head.wrap : !head.wrap;
      src_robid_1.idx  = src_idx_1;
      src_robid_1.wrap = (src_idx_1 >= head.idx) ? head.wrap : !head.wrap;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         head <= '0;
         tail <= '0;
      end else begin
         if (retire_valid) begin
            head <= incr_robid(head);
         end
         if (nuke) begin
            tail <= incr_robid(head);
         end else if (do_alloc) begin
            tail <= incr_robid(tail);
         end
      end
   end

   // Restore walk, youngest discarded entry first, down to the new head
   always_ff @(posedge clk) begin
      if (reset) begin
         rr_state <= RR_IDLE;
         rr_ptr   <= '0;
         rr_cnt   <= '0;
      end else begin
         case (rr_state)
            RR_IDLE: begin
               if (nuke) begin
                  rr_state <= RR_QUIET;
                  rr_ptr   <= decr_robid(tail);
                  rr_cnt   <= QCNT_W'(`QUIESCE_CYCLES - 1);
               end
            end
            RR_QUIET: begin
               if (rr_cnt == '0) begin
                  // Nothing younger than the flushed micro-op means no walk
                  rr_state <= (rr_ptr == decr_robid(head)) ? RR_RESUME : RR_WALK;
               end else begin
                  rr_cnt <= rr_cnt - 1'b1;
               end
            end
            RR_WALK: begin
               rr_ptr <= decr_robid(rr_ptr);
               if (rr_ptr == head) begin
                  rr_state <= RR_RESUME;
               end
            end
            default: rr_state <= RR_IDLE;
         endcase
      end
   end

   assign walk_on          = (rr_state == RR_WALK);
   assign restore_valid    = walk_on && walk_ent.has_dst;
   assign restore_areg     = walk_ent.dst_areg;
   assign restore_pdst_old = walk_ent.pdst_old;
   assign resume_fetch     = (rr_state == RR_RESUME);

   // Retire reclaims the displaced id, the walk returns the fresh one
   assign free_push_valid = (retire_valid && head_ent.has_dst) || restore_valid;
   assign free_push_pdst  = walk_on ? walk_ent.pdst_new : head_ent.pdst_old;

endmodule

`default_nettype wire

/* hdl/rob_consts.svh */
`ifndef ROB_CONSTS_SVH
`define ROB_CONSTS_SVH

// Reorder buffer slots, must be a power of two
`define ROB_NUM_ENTS 8
`define ROB_ID_W ($clog2(`ROB_NUM_ENTS))

// Register files
`define NUM_AREGS 32
`define NUM_PREGS 48
`define PREG_W ($clog2(`NUM_PREGS))

// Cycles between a nuke and the start of the restore walk
`define QUIESCE_CYCLES 5

`endif

/* hdl/rob_entry.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_entry
   import rob_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     alloc_en,
   input  logic     alloc_has_dst,
   input  t_areg    alloc_dst_areg,
   input  t_preg    alloc_pdst_new,
   input  t_preg    alloc_pdst_old,
   input  logic     result_en,
   input  logic     result_flush,
   input  logic     retire_en,
   input  logic     flush_young,
   output t_rob_ent entry
);

   logic  valid_q;
   logic  ready_q;
   logic  flush_q;
   logic  has_dst_q;
   t_areg dst_areg_q;
   t_preg pdst_new_q;
   t_preg pdst_old_q;

   // Completion state
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_q <= 1'b0;
         ready_q <= 1'b0;
         flush_q <= 1'b0;
      end else if (alloc_en) begin
         valid_q <= 1'b1;
         ready_q <= 1'b0;
         flush_q <= 1'b0;
      end else if (retire_en || flush_young) begin
         valid_q <= 1'b0;
      end else if (result_en && valid_q) begin
         ready_q <= 1'b1;
         flush_q <= flush_q | result_flush;
      end
   end

   // Static fields stay put after invalidation so the restore walk can read them
   always_ff @(posedge clk) begin
      if (alloc_en) begin
         has_dst_q  <= alloc_has_dst;
         dst_areg_q <= alloc_dst_areg;
         pdst_new_q <= alloc_pdst_new;
         pdst_old_q <= alloc_pdst_old;
      end
   end

   always_comb begin
      entry.valid        = valid_q;
      entry.ready        = ready_q;
      entry.flush_needed = flush_q;
      entry.has_dst      = has_dst_q;
      entry.dst_areg     = dst_areg_q;
      entry.pdst_new     = pdst_new_q;
      entry.pdst_old     = pdst_old_q;
   end

endmodule

`default_nettype wire

/* hdl/rob_pkg.sv */
`default_nettype none

`include "rob_consts.svh"

package rob_pkg;

   typedef logic [`ROB_ID_W-1:0] t_rob_idx;

   // Wrap bit tells full from empty when the indices match
   typedef struct packed {
      logic     wrap;
      t_rob_idx idx;
   } t_rob_id;

   typedef logic [$clog2(`NUM_AREGS)-1:0] t_areg;
   typedef logic [`PREG_W-1:0]            t_preg;

   typedef struct packed {
      logic  valid;
      logic  ready;
      logic  flush_needed;
      logic  has_dst;
      t_areg dst_areg;
      t_preg pdst_new;
      t_preg pdst_old;
   } t_rob_ent;

   typedef enum logic [1:0] {
      RR_IDLE,
      RR_QUIET,
      RR_WALK,
      RR_RESUME
   } t_rr_state;

   // Slot count is a power of two, so the carry lands in the wrap bit
   function automatic t_rob_id incr_robid(input t_rob_id id);
      return t_rob_id'(id + 1'b1);
   endfunction

   function automatic t_rob_id decr_robid(input t_rob_id id);
      return t_rob_id'(id - 1'b1);
   endfunction

endpackage

`default_nettype wire

/* hdl/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top
   import rob_pkg::*;
(
   input  logic    clk,
   input  logic    reset,
   input  logic    alloc,
   input  logic    alloc_has_dst,
   input  t_areg   alloc_dst_reg,
   input  t_areg   src_reg_0,
   input  t_areg   src_reg_1,
   input  logic    result_valid,
   input  t_rob_id result_robid,
   input  logic    result_flush,
   output logic    ready,
   output t_rob_id alloc_robid,
   output t_preg   alloc_pdst,
   output t_preg   src_pdst_0,
   output t_preg   src_pdst_1,
   output logic    src_pending_0,
   output logic    src_pending_1,
   output t_rob_id src_robid_0,
   output t_rob_id src_robid_1,
   output logic    retire_valid,
   output t_rob_id retire_robid,
   output t_areg   retire_dst_reg,
   output logic    reclaim_valid,
   output t_preg   reclaim_pdst,
   output logic    nuke,
   output logic    resume_fetch
);

   t_preg pdst_old;
   logic  free_avail;
   logic  free_push_valid;
   t_preg free_push_pdst;
   logic  restore_valid;
   t_areg restore_areg;
   t_preg restore_pdst_old;

   // Pushes in a retire cycle are always reclaims, the walk never overlaps retire
   assign reclaim_valid = free_push_valid && retire_valid;
   assign reclaim_pdst  = free_push_pdst;

   rob u_rob (
      .clk,
      .reset,
      .alloc,
      .alloc_has_dst,
      .alloc_dst_reg,
      .alloc_pdst_new  (alloc_pdst),
      .alloc_pdst_old  (pdst_old),
      .free_avail,
      .result_valid,
      .result_robid,
      .result_flush,
      .src_reg_0,
      .src_reg_1,
      .ready,
      .alloc_robid,
      .src_pending_0,
      .src_pending_1,
      .src_robid_0,
      .src_robid_1,
      .retire_valid,
      .retire_robid,
      .retire_dst_reg,
      .free_push_valid,
      .free_push_pdst,
      .restore_valid,
      .restore_areg,
      .restore_pdst_old,
      .nuke,
      .resume_fetch
   );

   rename_map u_map (
      .clk,
      .reset,
      .alloc,
      .alloc_has_dst,
      .alloc_dst_reg,
      .alloc_pdst_new  (alloc_pdst),
      .src_reg_0,
      .src_reg_1,
      .restore_valid,
      .restore_areg,
      .restore_pdst_old,
      .alloc_pdst_old  (pdst_old),
      .src_pdst_0,
      .src_pdst_1
   );

   prf_free_list u_free (
      .clk,
      .reset,
      .pop        (alloc && alloc_has_dst),
      .push_valid (free_push_valid),
      .push_pdst  (free_push_pdst),
      .head_pdst  (alloc_pdst),
      .avail      (free_avail)
   );

endmodule

`default_nettype wire

/* rob_top.f */
+incdir+hdl
hdl/rob_pkg.sv
hdl/rob_entry.sv
hdl/rob.sv
hdl/rename_map.sv
hdl/prf_free_list.sv
hdl/rob_top.sv
test/rob_props.sv
test/rob_top_tb.sv

/* test/rob_props.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_props
   import rob_pkg::*;
(
   input logic    clk,
   input logic    reset,
   input logic    alloc,
   input logic    ready,
   input logic    retire_valid,
   input logic    nuke,
   input t_rob_id head,
   input t_rob_id tail
);

   // Count of failed assertions
   int n_fail = 0;

   // The allocator may only present a micro-op while the buffer is ready
   a_alloc_ready: assert property (@(posedge clk) disable iff (reset)
      alloc |-> ready)
      else begin
         $error("alloc sampled while ready was low");
         n_fail++;
      end

   // In-order retirement, one slot per retire
   a_head_step: assert property (@(posedge clk) disable iff (reset)
      retire_valid |=> (head == t_rob_id'($past(head) + 1'b1)))
      else begin
         $error("head did not advance by one after a retire");
         n_fail++;
      end

   // A nuke retires the head and discards every younger slot
   a_nuke_empty: assert property (@(posedge clk) disable iff (reset)
      nuke |=> (tail == head))
      else begin
         $error("buffer not empty after a nuke");
         n_fail++;
      end

endmodule

bind rob rob_props props0 (
   .clk          (clk),
   .reset        (reset),
   .alloc        (alloc),
   .ready        (ready),
   .retire_valid (retire_valid),
   .nuke         (nuke),
   .head         (head),
   .tail         (tail)
);

`default_nettype wire

/* test/rob_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rob_consts.svh"

module rob_top_tb
   import rob_pkg::*;
();

   localparam int STIM_CYCLES  = 3000;
   localparam int DRAIN_CYCLES = 1000;
   localparam int MAX_CYCLES   = STIM_CYCLES + DRAIN_CYCLES;
   localparam int NUM_TESTS    = 5;

   // One in-flight micro-op as the model sees it
   typedef struct packed {
      t_rob_id id;
      logic    has_dst;
      t_areg   dst;
      t_preg   pnew;
      t_preg   pold;
      logic    rdy;
      logic    flush;
   } t_mop;

   logic    clk;
   logic    reset;
   logic    alloc;
   logic    alloc_has_dst;
   t_areg   alloc_dst_reg;
   t_areg   src_reg_0;
   t_areg   src_reg_1;
   logic    result_valid;
   t_rob_id result_robid;
   logic    result_flush;
   logic    ready;
   t_rob_id alloc_robid;
   t_preg   alloc_pdst;
   t_preg   src_pdst_0;
   t_preg   src_pdst_1;
   logic    src_pending_0;
   logic    src_pending_1;
   t_rob_id src_robid_0;
   t_rob_id src_robid_1;
   logic    retire_valid;
   t_rob_id retire_robid;
   t_areg   retire_dst_reg;
   logic    reclaim_valid;
   t_preg   reclaim_pdst;
   logic    nuke;
   logic    resume_fetch;

   integer seed;
   int     cycles;
   int     n_checks [NUM_TESTS];
   int     n_errs [NUM_TESTS];
   string  test_name [NUM_TESTS] = '{"retirement order", "reclaim", "source lookup",
                                     "flush recovery", "back-pressure"};

   // Reference model state
   t_mop   model_q [$];
   t_preg  free_q [$];
   t_preg  model_map [`NUM_AREGS];
   logic [`ROB_ID_W:0] tail_ctr;
   logic   recovering;
   logic   after_rec;
   int     rec_left;

   rob_top dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic int rand_below(input int n);
      return $unsigned($random(seed)) % n;
   endfunction

   task automatic check(input int test, input string what,
                        input logic [31:0] got, input logic [31:0] exp);
      n_checks[test]++;
      if (got !== exp) begin
         n_errs[test]++;
         $display("** Error at %0t ns: %s got %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   // Youngest in-flight writer of an architectural register
   task automatic find_writer(input t_areg r, output logic found, output t_rob_id id);
      found = 1'b0;
      id    = '0;
      for (int i = model_q.size() - 1; i >= 0; i--) begin
         if (!found && model_q[i].has_dst && model_q[i].dst == r) begin
            found = 1'b1;
            id    = model_q[i].id;
         end
      end
   endtask

   task automatic drive_cycle(input logic stim_on);
      int pick;
      alloc         = 1'b0;
      result_valid  = 1'b0;
      result_flush  = 1'b0;
      src_reg_0     = t_areg'(rand_below(`NUM_AREGS));
      src_reg_1     = t_areg'(rand_below(`NUM_AREGS));
      alloc_dst_reg = t_areg'(rand_below(`NUM_AREGS));
      alloc_has_dst = (rand_below(4) != 0);
      if (stim_on && ready && rand_below(4) != 0) begin
         alloc = 1'b1;
      end
      if (model_q.size() > 0 && rand_below(2) == 0) begin
         pick = rand_below(model_q.size());
         if (!model_q[pick].rdy) begin
            result_valid = 1'b1;
            result_robid = model_q[pick].id;
            result_flush = (rand_below(10) == 0);
         end
      end
   endtask

   task automatic step_model();
      logic    exp_retire;
      logic    exp_nuke;
      logic    exp_ready;
      logic    pend;
      t_rob_id wid;
      t_mop    ent;
      int      map_test;
      exp_retire = !recovering && (model_q.size() > 0) && model_q[0].rdy;
      exp_nuke   = exp_retire && model_q[0].flush;
      exp_ready  = !recovering && (model_q.size() < `ROB_NUM_ENTS) &&
                   (free_q.size() > 0) && !exp_nuke;
      check(4, "ready", ready, exp_ready);
      check(0, "retire_valid", retire_valid, exp_retire);
      check(3, "nuke", nuke, exp_nuke);
      check(3, "resume_fetch", resume_fetch, recovering && (rec_left == 1));
      if (exp_retire) begin
         check(0, "retire_robid", retire_robid, model_q[0].id);
         check(0, "retire_dst_reg", retire_dst_reg, model_q[0].dst);
         check(1, "reclaim_valid", reclaim_valid, model_q[0].has_dst);
         if (model_q[0].has_dst) begin
            check(1, "reclaim_pdst", reclaim_pdst, model_q[0].pold);
         end
      end else begin
         check(1, "reclaim_valid", reclaim_valid, 1'b0);
      end
      if (!recovering) begin
         map_test = after_rec ? 3 : 2;
         find_writer(src_reg_0, pend, wid);
         check(2, "src_pending_0", src_pending_0, pend);
         if (pend) begin
            check(2, "src_robid_0", src_robid_0, wid);
         end
         check(map_test, "src_pdst_0", src_pdst_0, model_map[src_reg_0]);
         find_writer(src_reg_1, pend, wid);
         check(2, "src_pending_1", src_pending_1, pend);
         if (pend) begin
            check(2, "src_robid_1", src_robid_1, wid);
         end
         check(map_test, "src_pdst_1", src_pdst_1, model_map[src_reg_1]);
      end
      if (alloc) begin
         check(1, "alloc_robid", alloc_robid, tail_ctr);
         if (free_q.size() > 0) begin
            check(1, "alloc_pdst", alloc_pdst, free_q[0]);
         end
      end

      // Results land at the coming edge
      if (result_valid) begin
         for (int i = 0; i < model_q.size(); i++) begin
            if (model_q[i].id == result_robid) begin
               model_q[i].rdy   = 1'b1;
               model_q[i].flush = model_q[i].flush | result_flush;
            end
         end
      end

      if (recovering) begin
         rec_left--;
         if (rec_left == 0) begin
            recovering = 1'b0;
            after_rec  = 1'b1;
         end
      end else if (exp_retire) begin
         ent = model_q.pop_front();
         if (ent.has_dst) begin
            free_q.push_back(ent.pold);
         end
         if (exp_nuke) begin
            tail_ctr   = ent.id + 1'b1;
            rec_left   = `QUIESCE_CYCLES + model_q.size() + 1;
            recovering = 1'b1;
            // Undo the discarded renames, youngest first
            while (model_q.size() > 0) begin
               ent = model_q.pop_back();
               if (ent.has_dst) begin
                  model_map[ent.dst] = ent.pold;
                  free_q.push_back(ent.pnew);
               end
            end
         end
      end

      if (alloc) begin
         ent.id      = tail_ctr;
         ent.has_dst = alloc_has_dst;
         ent.dst     = alloc_dst_reg;
         ent.pold    = model_map[alloc_dst_reg];
         ent.pnew    = '0;
         ent.rdy     = 1'b0;
         ent.flush   = 1'b0;
         if (alloc_has_dst) begin
            ent.pnew = free_q.pop_front();
            model_map[alloc_dst_reg] = ent.pnew;
         end
         model_q.push_back(ent);
         tail_ctr  = tail_ctr + 1'b1;
         after_rec = 1'b0;
      end
   endtask

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout after %0d cycles, the buffer never drained", cycles);
      $display("tests failed");
      $finish;
   end

   initial begin
      int total_checks;
      int total_errs;
      seed          = 32'hf53d_4ad2;
      reset         = 1'b1;
      alloc         = 1'b0;
      alloc_has_dst = 1'b0;
      alloc_dst_reg = '0;
      src_reg_0     = '0;
      src_reg_1     = '0;
      result_valid  = 1'b0;
      result_robid  = '0;
      result_flush  = 1'b0;
      total_checks  = 0;
      total_errs    = 0;
      tail_ctr      = '0;
      recovering    = 1'b0;
      after_rec     = 1'b0;
      rec_left      = 0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         n_checks[t] = 0;
         n_errs[t]   = 0;
      end
      // Identity map and ids 32..47 free, as after reset
      for (int i = 0; i < `NUM_AREGS; i++) begin
         model_map[i] = t_preg'(i);
      end
      for (int i = `NUM_AREGS; i < `NUM_PREGS; i++) begin
         free_q.push_back(t_preg'(i));
      end
      repeat (2) @(negedge clk);
      reset = 1'b0;

      for (int c = 0; c < STIM_CYCLES; c++) begin
         @(negedge clk);
         drive_cycle(1'b1);
         #1;
         step_model();
      end
      // Drain with results only
      while (model_q.size() > 0 || recovering) begin
         @(negedge clk);
         drive_cycle(1'b0);
         #1;
         step_model();
      end

      for (int t = 0; t < NUM_TESTS; t++) begin
         $display("Test %0d %s: %0d checks, %0d errors", t + 1, test_name[t],
                  n_checks[t], n_errs[t]);
         total_checks += n_checks[t];
         total_errs   += n_errs[t];
      end
      $display("Total: %0d checks, %0d errors, %0d assertion failures", total_checks,
               total_errs, dut0.u_rob.props0.n_fail);
      if (total_errs == 0 && dut0.u_rob.props0.n_fail == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
